// File: build.f
design/mem_front_pkg.sv
design/line_cache.sv
design/load_align.sv
design/mem_ctrl.sv
design/mem_front_top.sv
test/line_memory_model.sv
test/tb_mem_front.sv

// File: Makefile
TOP = tb_mem_front

.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module $(TOP) -f build.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Some tests failed" sim.log; then \
		echo "simulation FAILED"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: test/tb_mem_front.sv
`timescale 1ns/1ps

module tb_mem_front;
	import mem_front_pkg::*;

	localparam int TIMEOUT   = 50;
	localparam int MEM_WORDS = 16384;

	logic              clk;
	logic              rst_n_i;
	logic              if_req_i;
	logic [ADDR_W-1:0] if_addr_i;
	logic              if_valid_o;
	logic [WORD_W-1:0] if_data_o;
	logic              d_req_i;
	core_req_t         d_cmd_i;
	logic              d_done_o;
	logic [WORD_W-1:0] d_rdata_o;
	logic              mem_read_o;
	logic [ADDR_W-1:0] mem_read_addr_o;
	logic              mem_data_ready;
	mem_rsp_t          mem_rsp;
	logic              mem_write_o;
	mem_wr_t           mem_wr_o;
	logic [31:0]       read_cnt;

	// reference image of memory, kept up to date with every store
	logic [31:0] ref_mem [MEM_WORDS];
	logic [31:0] exp_if;
	logic [31:0] exp_d;
	logic        exp_d_store;
	mem_wr_t     exp_wr;
	logic [ADDR_W-1:0] exp_rd_addr;
	int          err_cnt;
	int          chk_err_cnt;
	int          test_err_base;
	int          pass_cnt;
	int          fail_cnt;
	string       test_name;
	logic [31:0] base;

	mem_front_top #(
		.I_LINES (8),
		.D_LINES (8)
	) u_dut (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.if_req_i         (if_req_i),
		.if_addr_i        (if_addr_i),
		.if_valid_o       (if_valid_o),
		.if_data_o        (if_data_o),
		.d_req_i          (d_req_i),
		.d_cmd_i          (d_cmd_i),
		.d_done_o         (d_done_o),
		.d_rdata_o        (d_rdata_o),
		.mem_read_o       (mem_read_o),
		.mem_read_addr_o  (mem_read_addr_o),
		.mem_data_ready_i (mem_data_ready),
		.mem_rsp_i        (mem_rsp),
		.mem_write_o      (mem_write_o),
		.mem_wr_o         (mem_wr_o)
	);

	line_memory_model #(
		.WORDS (MEM_WORDS)
	) u_mem (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.mem_read_i       (mem_read_o),
		.mem_read_addr_i  (mem_read_addr_o),
		.mem_data_ready_o (mem_data_ready),
		.mem_rsp_o        (mem_rsp),
		.mem_write_i      (mem_write_o),
		.mem_wr_i         (mem_wr_o),
		.read_cnt_o       (read_cnt)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] fill_word(input logic [31:0] waddr);
		return (waddr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
	endfunction

	// expected load result, bytes are sign-extended
	function automatic logic [31:0] ref_load(input logic [ADDR_W-1:0] addr,
		input bit is_byte);
		logic [31:0] w;
		logic [7:0]  b;
		w = ref_mem[addr[15:2]];
		b = w[{addr[1:0], 3'b0} +: 8];
		if (is_byte) begin
			return {{24{b[7]}}, b};
		end
		return w;
	endfunction

	function automatic void mirror_store(input logic [ADDR_W-1:0] addr, input logic [31:0] wdata,
		input bit is_byte);
		if (is_byte) begin
			ref_mem[addr[15:2]][{addr[1:0], 3'b0} +: 8] = wdata[7:0];
		end else begin
			ref_mem[addr[15:2]] = wdata;
		end
	endfunction

	// compares every result pulse against the value the stimulus expects
	always @(negedge clk) begin
		if (rst_n_i) begin
			if (if_valid_o === 1'b1 && if_data_o !== exp_if) begin
				$display("Error at %0t: if_data_o = %h, expected %h", $time, if_data_o, exp_if);
				chk_err_cnt++;
			end
			if (d_done_o === 1'b1 && !exp_d_store && d_rdata_o !== exp_d) begin
				$display("Error at %0t: d_rdata_o = %h, expected %h", $time, d_rdata_o, exp_d);
				chk_err_cnt++;
			end
			// a line read always asks for the start of the line
			if (mem_read_o === 1'b1 && mem_read_addr_o !== exp_rd_addr) begin
				$display("Error at %0t: mem_read_addr_o = %h, expected %h", $time,
					mem_read_addr_o, exp_rd_addr);
				chk_err_cnt++;
			end
			if (mem_write_o === 1'b1) begin
				if (!exp_d_store || mem_wr_o.addr !== exp_wr.addr
					|| mem_wr_o.is_byte !== exp_wr.is_byte
					|| mem_wr_o.data[7:0] !== exp_wr.data[7:0]
					|| (!exp_wr.is_byte && mem_wr_o.data !== exp_wr.data)) begin
					$display("Error at %0t: mem_wr_o = %h, expected %h", $time,
						mem_wr_o, exp_wr);
					chk_err_cnt++;
				end
			end
		end
	end

	task automatic wait_pulse(input bit is_fetch);
		int cyc;
		bit seen;
		cyc = 0;
		seen = 1'b0;
		while (!seen && cyc < TIMEOUT) begin
			@(negedge clk);
			cyc++;
			if (is_fetch) begin
				seen = (if_valid_o === 1'b1);
			end else begin
				seen = (d_done_o === 1'b1);
				// a pending data request must finish before any fetch
				if (if_valid_o === 1'b1) begin
					$display("fetch completed while a data request was pending at %0t", $time);
					err_cnt++;
				end
			end
		end
		if (!seen) begin
			$display("timeout at %0t, no %s pulse arrived", $time,
				is_fetch ? "if_valid_o" : "d_done_o");
			err_cnt++;
		end
	endtask

	task automatic fetch_word(input logic [ADDR_W-1:0] addr);
		@(posedge clk);
		exp_if = ref_load(addr, 1'b0);
		exp_rd_addr = addr & ~20'hf;
		if_req_i <= 1'b1;
		if_addr_i <= addr;
		wait_pulse(1'b1);
		@(posedge clk);
		if_req_i <= 1'b0;
	endtask

	task automatic data_access(input logic [ADDR_W-1:0] addr, input logic [31:0] wdata,
		input bit is_byte, input bit is_store);
		core_req_t cmd;
		cmd.addr = addr;
		cmd.wdata = wdata;
		cmd.is_byte = is_byte;
		cmd.is_store = is_store;
		@(posedge clk);
		exp_d = ref_load(addr, is_byte);
		exp_d_store = is_store;
		exp_wr.addr = addr;
		exp_wr.data = is_byte ? {24'h0, wdata[7:0]} : wdata;
		exp_wr.is_byte = is_byte;
		exp_rd_addr = addr & ~20'hf;
		d_req_i <= 1'b1;
		d_cmd_i <= cmd;
		wait_pulse(1'b0);
		if (is_store) begin
			if (mem_write_o !== 1'b1) begin
				$display("mem_write_o did not pulse with d_done_o for a store at %0t", $time);
				err_cnt++;
			end
			mirror_store(addr, wdata, is_byte);
		end
		@(posedge clk);
		d_req_i <= 1'b0;
	endtask

	task automatic fetch_and_load(input logic [ADDR_W-1:0] i_addr,
		input logic [ADDR_W-1:0] d_addr);
		core_req_t cmd;
		cmd = '0;
		cmd.addr = d_addr;
		@(posedge clk);
		exp_if = ref_load(i_addr, 1'b0);
		exp_d = ref_load(d_addr, 1'b0);
		exp_d_store = 1'b0;
		exp_rd_addr = d_addr & ~20'hf;
		if_req_i <= 1'b1;
		if_addr_i <= i_addr;
		d_req_i <= 1'b1;
		d_cmd_i <= cmd;
		wait_pulse(1'b0);
		// the fetch line is read only after the load has finished
		exp_rd_addr = i_addr & ~20'hf;
		@(posedge clk);
		d_req_i <= 1'b0;
		wait_pulse(1'b1);
		@(posedge clk);
		if_req_i <= 1'b0;
	endtask

	task automatic check_reads(input logic [31:0] expected);
		if (read_cnt !== expected) begin
			$display("Error at %0t: mem_read_o count = %0d, expected %0d", $time,
				read_cnt, expected);
			err_cnt++;
		end
	endtask

	task automatic apply_reset();
		rst_n_i <= 1'b0;
		repeat (8) @(posedge clk);
		rst_n_i <= 1'b1;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err_base = err_cnt + chk_err_cnt;
	endtask

	task automatic end_test();
		if (err_cnt + chk_err_cnt == test_err_base) begin
			pass_cnt++;
			$display("test %s: ok", test_name);
		end else begin
			fail_cnt++;
			$display("test %s: FAILED", test_name);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n_i = 1'b0;
		if_req_i = 1'b0;
		if_addr_i = '0;
		d_req_i = 1'b0;
		d_cmd_i = '0;
		exp_if = '0;
		exp_d = '0;
		exp_d_store = 1'b0;
		exp_wr = '0;
		exp_rd_addr = '0;
		err_cnt = 0;
		chk_err_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[14'(i)] = fill_word(32'(i));
		end
		apply_reset();

		begin_test("fetch miss then hit");
		base = read_cnt;
		fetch_word(20'h00200);
		check_reads(base + 32'd1);
		fetch_word(20'h00208);
		check_reads(base + 32'd1);
		end_test();

		// each line misses on its first access, starting mid-line
		begin_test("word and byte loads");
		base = read_cnt;
		for (int k = 0; k < 4; k++) begin
			data_access(20'h00340 + 20'((k * 4 + 8) % 16), '0, 1'b0, 1'b0);
		end
		for (int k = 0; k < 16; k++) begin
			data_access(20'h00450 + 20'((k + 11) % 16), '0, 1'b1, 1'b0);
		end
		check_reads(base + 32'd2);
		end_test();

		begin_test("store then load");
		base = read_cnt;
		data_access(20'h00344, 32'hdead_beef, 1'b0, 1'b1);
		data_access(20'h00349, 32'h1234_56c3, 1'b1, 1'b1);
		data_access(20'h00344, '0, 1'b0, 1'b0);
		data_access(20'h00349, '0, 1'b1, 1'b0);
		data_access(20'h00348, '0, 1'b0, 1'b0);
		check_reads(base);
		// line 0x560 is not cached, so the load after the store must go to memory
		data_access(20'h00564, 32'h0bad_f00d, 1'b0, 1'b1);
		check_reads(base);
		data_access(20'h00564, '0, 1'b0, 1'b0);
		check_reads(base + 32'd1);
		end_test();

		begin_test("conflict eviction");
		base = read_cnt;
		for (int k = 0; k < 4; k++) begin
			data_access((k % 2 == 0) ? 20'h00100 : 20'h00500, '0, 1'b0, 1'b0);
			check_reads(base + 32'(k + 1));
		end
		end_test();

		begin_test("fetch and load together");
		base = read_cnt;
		fetch_and_load(20'h00730, 20'h00710);
		check_reads(base + 32'd2);
		end_test();

		begin_test("second reset");
		base = read_cnt;
		fetch_word(20'h00204);
		check_reads(base);
		apply_reset();
		base = read_cnt;
		fetch_word(20'h00204);
		check_reads(base + 32'd1);
		end_test();

		$display("%0d tests passed, %0d tests failed, %0d errors", pass_cnt, fail_cnt,
			err_cnt + chk_err_cnt);
		if (err_cnt + chk_err_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: test/line_memory_model.sv
`timescale 1ns/1ps

module line_memory_model #(
	parameter int WORDS = 16384
) (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  logic                             mem_read_i,
	input  logic [mem_front_pkg::ADDR_W-1:0] mem_read_addr_i,
	output logic                             mem_data_ready_o,
	output mem_front_pkg::mem_rsp_t          mem_rsp_o,
	input  logic                             mem_write_i,
	input  mem_front_pkg::mem_wr_t           mem_wr_i,
	output logic [31:0]                      read_cnt_o
);
	import mem_front_pkg::*;

	localparam int          AW   = $clog2(WORDS);
	localparam logic [31:0] SEED = 32'h8a28_8240;

	logic [31:0]       mem [WORDS];
	logic [31:0]       rng_q;
	logic              busy_q;
	logic [2:0]        wait_q;
	logic [ADDR_W-1:0] addr_q;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// every word gets a value that depends on its whole address
	function automatic logic [31:0] fill_word(input logic [31:0] waddr);
		return (waddr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
	endfunction

	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[AW'(i)] = fill_word(32'(i));
		end
	end

	always @(posedge clk) begin
		if (!rst_n_i) begin
			rng_q            <= SEED;
			busy_q           <= 1'b0;
			wait_q           <= 3'd0;
			addr_q           <= '0;
			mem_data_ready_o <= 1'b0;
			mem_rsp_o        <= '0;
			read_cnt_o       <= '0;
		end else begin
			// ready stays high for one cycle together with the line
			mem_data_ready_o <= 1'b0;
			if (mem_read_i) begin
				busy_q     <= 1'b1;
				addr_q     <= mem_read_addr_i;
				wait_q     <= 3'(rng_q % 32'd6);
				rng_q      <= xorshift(rng_q);
				read_cnt_o <= read_cnt_o + 32'd1;
			end else if (busy_q) begin
				if (wait_q == 3'd0) begin
					busy_q           <= 1'b0;
					mem_data_ready_o <= 1'b1;
					mem_rsp_o.addr   <= addr_q;
					mem_rsp_o.data   <= {mem[{addr_q[AW+1:4], 2'd3}], mem[{addr_q[AW+1:4], 2'd2}],
						mem[{addr_q[AW+1:4], 2'd1}], mem[{addr_q[AW+1:4], 2'd0}]};
				end else begin
					wait_q <= wait_q - 3'd1;
				end
			end
			// byte lanes are little endian inside each word
			if (mem_write_i) begin
				if (mem_wr_i.is_byte) begin
					mem[mem_wr_i.addr[AW+1:2]][{mem_wr_i.addr[1:0], 3'b0} +: 8] <= mem_wr_i.data[7:0];
				end else begin
					mem[mem_wr_i.addr[AW+1:2]] <= mem_wr_i.data;
				end
			end
		end
	end

endmodule

// File: design/mem_front_top.sv
`timescale 1ns/1ps

module mem_front_top #(
	parameter int I_LINES = 8,
	parameter int D_LINES = 8
) (
	input  logic                             clk,
	input  logic                             rst_n_i,

	// instruction side
	input  logic                             if_req_i,
	input  logic [mem_front_pkg::ADDR_W-1:0] if_addr_i,
	output logic                             if_valid_o,
	output logic [mem_front_pkg::WORD_W-1:0] if_data_o,

	// data side
	input  logic                             d_req_i,
	input  mem_front_pkg::core_req_t         d_cmd_i,
	output logic                             d_done_o,
	output logic [mem_front_pkg::WORD_W-1:0] d_rdata_o,

	// memory side
	output logic                             mem_read_o,
	output logic [mem_front_pkg::ADDR_W-1:0] mem_read_addr_o,
	input  logic                             mem_data_ready_i,
	input  mem_front_pkg::mem_rsp_t          mem_rsp_i,
	output logic                             mem_write_o,
	output mem_front_pkg::mem_wr_t           mem_wr_o
);
	import mem_front_pkg::*;

	logic              i_hit;
	logic              d_hit;
	logic              i_fill;
	logic              d_fill;
	logic              d_merge;
	logic [LINE_W-1:0] fill_line;
	logic [LINE_W-1:0] i_line;
	logic [LINE_W-1:0] d_line;
	logic [LINE_W-1:0] d_merged;

	mem_ctrl u_ctrl (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.if_req_i         (if_req_i),
		.if_addr_i        (if_addr_i),
		.d_req_i          (d_req_i),
		.d_cmd_i          (d_cmd_i),
		.i_hit_i          (i_hit),
		.d_hit_i          (d_hit),
		.mem_data_ready_i (mem_data_ready_i),
		.mem_rsp_i        (mem_rsp_i),
		.i_fill_o         (i_fill),
		.d_fill_o         (d_fill),
		.d_merge_o        (d_merge),
		.fill_line_o      (fill_line),
		.mem_read_o       (mem_read_o),
		.mem_read_addr_o  (mem_read_addr_o),
		.mem_write_o      (mem_write_o),
		.mem_wr_o         (mem_wr_o),
		.if_valid_o       (if_valid_o),
		.d_done_o         (d_done_o)
	);

	// the instruction cache is never written by stores
	line_cache #(
		.LINES (I_LINES)
	) u_icache (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.addr_i       (if_addr_i),
		.fill_en_i    (i_fill),
		.fill_line_i  (fill_line),
		.merge_en_i   (1'b0),
		.merge_line_i ('0),
		.hit_o        (i_hit),
		.line_o       (i_line)
	);

	line_cache #(
		.LINES (D_LINES)
	) u_dcache (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.addr_i       (d_cmd_i.addr),
		.fill_en_i    (d_fill),
		.fill_line_i  (fill_line),
		.merge_en_i   (d_merge),
		.merge_line_i (d_merged),
		.hit_o        (d_hit),
		.line_o       (d_line)
	);

	// fetches are always whole words
	load_align u_ialign (
		.line_i    (i_line),
		.addr_i    (if_addr_i[OFS_W-1:0]),
		.is_byte_i (1'b0),
		.wdata_i   ('0),
		.rdata_o   (if_data_o),
		.merged_o  ()
	);

	load_align u_dalign (
		.line_i    (d_line),
		.addr_i    (d_cmd_i.addr[OFS_W-1:0]),
		.is_byte_i (d_cmd_i.is_byte),
		.wdata_i   (d_cmd_i.wdata),
		.rdata_o   (d_rdata_o),
		.merged_o  (d_merged)
	);

endmodule

// File: design/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  logic                             if_req_i,
	input  logic [mem_front_pkg::ADDR_W-1:0] if_addr_i,
	input  logic                             d_req_i,
	input  mem_front_pkg::core_req_t         d_cmd_i,
	input  logic                             i_hit_i,
	input  logic                             d_hit_i,
	input  logic                             mem_data_ready_i,
	input  mem_front_pkg::mem_rsp_t          mem_rsp_i,
	output logic                             i_fill_o,
	output logic                             d_fill_o,
	output logic                             d_merge_o,
	output logic [mem_front_pkg::LINE_W-1:0] fill_line_o,
	output logic                             mem_read_o,
	output logic [mem_front_pkg::ADDR_W-1:0] mem_read_addr_o,
	output logic                             mem_write_o,
	output mem_front_pkg::mem_wr_t           mem_wr_o,
	output logic                             if_valid_o,
	output logic                             d_done_o
);
	import mem_front_pkg::*;

	ctrl_state_e state_q;
	ctrl_state_e state_d;

	// line address of the read in flight, compared against the echo
	logic [ADDR_W-1:0] req_addr_q;
	logic [ADDR_W-1:0] rd_addr_d;
	logic              issue_read;
	logic              rsp_match;

	function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] addr);
		line_base = {addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
	endfunction

	// a response counts only when it carries the line that was asked for
	assign rsp_match = mem_data_ready_i && (mem_rsp_i.addr == req_addr_q);

	// next state
	// data requests win over fetches when both are present in IDLE
	always_comb begin
		state_d    = state_q;
		issue_read = 1'b0;
		rd_addr_d  = line_base(if_addr_i);
		case (state_q)
			IDLE: begin
				if (d_req_i) begin
					rd_addr_d = line_base(d_cmd_i.addr);
					if (d_cmd_i.is_store) begin
						// stores go straight to memory, hit or miss
						state_d = STORE;
					end else if (d_hit_i) begin
						state_d = DATA_HIT;
					end else begin
						state_d    = DATA_FILL;
						issue_read = 1'b1;
					end
				end else if (if_req_i) begin
					if (i_hit_i) begin
						state_d = IFETCH_HIT;
					end else begin
						state_d    = IFETCH_FILL;
						issue_read = 1'b1;
					end
				end
			end
			// wait as long as memory needs, then answer from the freshly filled line
			DATA_FILL: begin
				if (rsp_match) begin
					state_d = DATA_HIT;
				end
			end
			IFETCH_FILL: begin
				if (rsp_match) begin
					state_d = IFETCH_HIT;
				end
			end
			// hit states and STORE hold for one cycle only
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q    <= IDLE;
			mem_read_o <= 1'b0;
		end else begin
			state_q    <= state_d;
			mem_read_o <= issue_read;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_read) begin
			req_addr_q <= rd_addr_d;
		end
	end

	assign mem_read_addr_o = req_addr_q;

	// the line is written into the cache on the edge that accepts the response
	assign i_fill_o    = (state_q == IFETCH_FILL) && rsp_match;
	assign d_fill_o    = (state_q == DATA_FILL) && rsp_match;
	assign fill_line_o = mem_rsp_i.data;

	// the cache itself decides whether the store hits and the line is merged
	assign d_merge_o   = (state_q == STORE);
	assign mem_write_o = (state_q == STORE);

	// the core holds its request through STORE, so the write payload comes
	// straight from it
	always_comb begin
		mem_wr_o.addr    = d_cmd_i.addr;
		mem_wr_o.is_byte = d_cmd_i.is_byte;
		if (d_cmd_i.is_byte) begin
			mem_wr_o.data = {{(WORD_W-8){1'b0}}, d_cmd_i.wdata[7:0]};
		end else begin
			mem_wr_o.data = d_cmd_i.wdata;
		end
	end

	assign if_valid_o = (state_q == IFETCH_HIT);
	assign d_done_o   = (state_q == DATA_HIT) || (state_q == STORE);

endmodule

// File: design/load_align.sv
`timescale 1ns/1ps

module load_align (
	input  logic [mem_front_pkg::LINE_W-1:0] line_i,
	input  logic [mem_front_pkg::OFS_W-1:0]  addr_i,
	input  logic                             is_byte_i,
	input  logic [mem_front_pkg::WORD_W-1:0] wdata_i,
	output logic [mem_front_pkg::WORD_W-1:0] rdata_o,
	output logic [mem_front_pkg::LINE_W-1:0] merged_o
);
	import mem_front_pkg::*;

	localparam int BYTE_W = 8;
	// bit position of a word or a byte inside the line
	localparam int POS_W = $clog2(LINE_W);

	logic [POS_W-1:0]  word_pos;
	logic [POS_W-1:0]  byte_pos;
	logic [WORD_W-1:0] word_sel;
	logic [BYTE_W-1:0] byte_sel;

	// word select uses addr[3:2], byte select the whole offset
	assign word_pos = {addr_i[OFS_W-1:2], 5'b0};
	assign byte_pos = {addr_i, 3'b0};

	assign word_sel = line_i[word_pos +: WORD_W];
	assign byte_sel = line_i[byte_pos +: BYTE_W];

	// byte loads are sign-extended to a full word
	always_comb begin
		if (is_byte_i) begin
			rdata_o = {{(WORD_W-BYTE_W){byte_sel[BYTE_W-1]}}, byte_sel};
		end else begin
			rdata_o = word_sel;
		end
	end

	// the line as it looks after the store, written back on a store hit
	always_comb begin
		merged_o = line_i;
		if (is_byte_i) begin
			merged_o[byte_pos +: BYTE_W] = wdata_i[BYTE_W-1:0];
		end else begin
			merged_o[word_pos +: WORD_W] = wdata_i;
		end
	end

endmodule

// File: design/line_cache.sv
`timescale 1ns/1ps

module line_cache #(
	parameter int LINES = 8
) (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  logic [mem_front_pkg::ADDR_W-1:0] addr_i,
	input  logic                             fill_en_i,
	input  logic [mem_front_pkg::LINE_W-1:0] fill_line_i,
	input  logic                             merge_en_i,
	input  logic [mem_front_pkg::LINE_W-1:0] merge_line_i,
	output logic                             hit_o,
	output logic [mem_front_pkg::LINE_W-1:0] line_o
);
	import mem_front_pkg::*;

	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = ADDR_W - OFS_W - IDX_W;

	logic [TAG_W-1:0]  tag_q [LINES];
	logic [LINE_W-1:0] line_q [LINES];
	logic [LINES-1:0]  valid_q;

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;

	// the index sits right above the byte offset, the tag takes the rest
	assign idx = addr_i[OFS_W +: IDX_W];
	assign tag = addr_i[ADDR_W-1 -: TAG_W];

	// lookup is purely combinational so a hit can be answered in the same cycle
	assign hit_o  = valid_q[idx] && (tag_q[idx] == tag);
	assign line_o = line_q[idx];

	// reset clears every valid bit, so each line misses until it is filled again
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else if (fill_en_i) begin
			valid_q[idx] <= 1'b1;
		end
	end

	// a fill replaces whatever was held at this index
	// a merge only touches a line that is actually present, so a store miss
	// never allocates
	always_ff @(posedge clk) begin
		if (fill_en_i) begin
			tag_q[idx]  <= tag;
			line_q[idx] <= fill_line_i;
		end else if (merge_en_i && hit_o) begin
			line_q[idx] <= merge_line_i;
		end
	end

endmodule

// File: design/mem_front_pkg.sv
package mem_front_pkg;

	// byte address width seen by the core and the memory
	localparam int ADDR_W = 20;

	// one cache line holds four 32-bit words
	localparam int LINE_W = 128;
	localparam int WORD_W = 32;

	// byte offset bits inside a line
	localparam int OFS_W = 4;

	// data request from the core, held as a level until d_done_o
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
		logic              is_byte;
		logic              is_store;
	} core_req_t;

	// line read response, the address is echoed back by the memory
	typedef struct packed {
		logic [LINE_W-1:0] data;
		logic [ADDR_W-1:0] addr;
	} mem_rsp_t;

	// write request to memory
	// for a byte write the data sits in the low 8 bits
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] data;
		logic              is_byte;
	} mem_wr_t;

	// controller states
	// the hit states and STORE last exactly one cycle and carry the done pulse
	typedef enum logic [2:0] {
		IDLE        = 3'd0,
		DATA_HIT    = 3'd1,
		IFETCH_HIT  = 3'd2,
		DATA_FILL   = 3'd3,
		IFETCH_FILL = 3'd4,
		STORE       = 3'd5
	} ctrl_state_e;

endpackage
